// ==== hdl/pb_link_pkg.sv ====
`default_nettype none

package pb_link_pkg;

    // index of the one set switch
    typedef logic [2:0] code_t;

    // one-hot so each state is a single flop
    typedef enum logic [3:0] {
        m_idle = 4'b0001,
        m_req  = 4'b0010,
        m_hold = 4'b0100,
        m_send = 4'b1000
    } master_state_e;

    typedef enum logic [1:0] {
        s_idle = 2'd0,
        s_hold = 2'd1, // notice lit, counting
        s_ack  = 2'd2  // ack up, waiting for valid
    } slave_state_e;

    localparam int default_hold_cycles  = 100_000_000; // one second at 100 MHz
    localparam int default_debounce_len = 4;

endpackage

`default_nettype wire

// ==== hdl/link_if.sv ====
`default_nettype none

interface link_if import pb_link_pkg::*; ();

    logic  request;
    logic  ack;
    logic  valid;
    code_t data;

    modport master (
        output request,
        output valid,
        output data,
        input  ack
    );

    modport slave (
        input  request,
        input  valid,
        input  data,
        output ack
    );

endinterface

`default_nettype wire

// ==== hdl/btn_conditioner.sv ====
`default_nettype none

module btn_conditioner #(
    parameter int DEBOUNCE_LEN = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic pulse
);

    logic [DEBOUNCE_LEN-1:0] history;
    logic                    pressed;
    logic                    pressed_q;

    // newest sample enters at bit 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history <= '0;
        end else begin
            history <= {history[DEBOUNCE_LEN-2:0], btn};
        end
    end

    assign pressed = &history; // stable high for the whole window

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pressed_q <= 1'b0;
            pulse     <= 1'b0;
        end else begin
            pressed_q <= pressed;
            pulse     <= pressed & ~pressed_q; // rising edge only
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hold_timer.sv ====
`default_nettype none

module hold_timer #(
    parameter int HOLD_CYCLES = 100_000_000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(HOLD_CYCLES - 1);

    logic [CNT_W-1:0] count;
    logic             at_end;

    assign at_end = (count == LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!start) begin
            count <= '0; // idle, hold at zero
        end else if (at_end) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // count is 0 on the first cycle start is high,
    // so this lands on the HOLD_CYCLES-th cycle
    assign done = start & at_end;

endmodule

`default_nettype wire

// ==== hdl/master_ctrl.sv ====
`default_nettype none

module master_ctrl import pb_link_pkg::*; #(
    parameter int HOLD_CYCLES = default_hold_cycles
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        send,
    input  logic [7:0]  sw,
    link_if.master      link,
    output logic        notice,
    output code_t       tx_code
);

    master_state_e state;
    master_state_e next_state;
    logic          hold_start;
    logic          hold_done;
    code_t         data_q;

    // switch encoder, anything not one-hot gives 0
    always_comb begin
        unique case (sw)
            8'b0000_0010: tx_code = 3'd1;
            8'b0000_0100: tx_code = 3'd2;
            8'b0000_1000: tx_code = 3'd3;
            8'b0001_0000: tx_code = 3'd4;
            8'b0010_0000: tx_code = 3'd5;
            8'b0100_0000: tx_code = 3'd6;
            8'b1000_0000: tx_code = 3'd7;
            default:      tx_code = 3'd0;
        endcase
    end

    assign hold_start = (state == m_hold);

    hold_timer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_hold (
        .clk   (clk),
        .rst_n (rst_n),
        .start (hold_start),
        .done  (hold_done)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= m_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            m_idle: begin
                if (send) begin
                    next_state = m_req;
                end
            end
            m_req: begin
                if (link.ack) begin
                    next_state = m_hold;
                end
            end
            m_hold: begin
                if (hold_done) begin
                    next_state = m_send;
                end
            end
            m_send: begin
                if (!link.ack) begin
                    next_state = m_idle; // slave took the data
                end
            end
            default: begin
                next_state = m_idle;
            end
        endcase
    end

    // launch register, frozen while valid is up
    always_ff @(posedge clk) begin
        if (hold_done) begin
            data_q <= tx_code;
        end
    end

    assign link.request = (state == m_req);
    assign link.valid   = (state == m_send);
    assign link.data    = data_q;
    assign notice       = hold_start; // lit during the hold

endmodule

`default_nettype wire

// ==== hdl/slave_ctrl.sv ====
`default_nettype none

module slave_ctrl import pb_link_pkg::*; #(
    parameter int HOLD_CYCLES = default_hold_cycles
) (
    input  logic   clk,
    input  logic   rst_n,
    link_if.slave  link,
    output logic   notice,
    output code_t  rx_data,
    output logic   rx_valid
);

    slave_state_e state;
    slave_state_e next_state;
    logic         hold_start;
    logic         hold_done;
    logic         take;

    assign hold_start = (state == s_hold);
    assign take       = (state == s_ack) & link.valid; // first valid cycle

    hold_timer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_hold (
        .clk   (clk),
        .rst_n (rst_n),
        .start (hold_start),
        .done  (hold_done)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        unique case (state)
            s_idle: begin
                if (link.request) begin
                    next_state = s_hold;
                end
            end
            s_hold: begin
                if (hold_done) begin
                    next_state = s_ack;
                end
            end
            s_ack: begin
                if (link.valid) begin
                    next_state = s_idle; // ack drops with this
                end
            end
            default: begin
                next_state = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_data  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= take;
            if (take) begin
                rx_data <= link.data;
            end
        end
    end

    assign link.ack = (state == s_ack);
    assign notice   = hold_start;

endmodule

`default_nettype wire

// ==== hdl/seg_display.sv ====
`default_nettype none

module seg_display import pb_link_pkg::*; (
    input  code_t      code,
    output logic [6:0] seg
);

    // active low, bit 0 is segment a, bit 6 is g
    always_comb begin
        unique case (code)
            3'd0:    seg = 7'b100_0000;
            3'd1:    seg = 7'b111_1001;
            3'd2:    seg = 7'b010_0100;
            3'd3:    seg = 7'b011_0000;
            3'd4:    seg = 7'b001_1001;
            3'd5:    seg = 7'b001_0010;
            3'd6:    seg = 7'b000_0010;
            3'd7:    seg = 7'b111_1000;
            default: seg = 7'b111_1111; // blank
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/pb_link_top.sv ====
`default_nettype none

module pb_link_top import pb_link_pkg::*; #(
    parameter int HOLD_CYCLES  = default_hold_cycles,
    parameter int DEBOUNCE_LEN = default_debounce_len
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] sw,
    input  logic       send_btn,
    output logic       notice_master,
    output logic       notice_slave,
    output code_t      rx_data,
    output logic       rx_valid,
    output logic [6:0] seg_master,
    output logic [6:0] seg_slave
);

    logic  send_pulse;
    code_t tx_code;

    link_if u_link ();

    btn_conditioner #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) u_btn (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (send_btn),
        .pulse (send_pulse)
    );

    master_ctrl #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_master (
        .clk     (clk),
        .rst_n   (rst_n),
        .send    (send_pulse),
        .sw      (sw),
        .link    (u_link.master),
        .notice  (notice_master),
        .tx_code (tx_code)
    );

    slave_ctrl #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_slave (
        .clk      (clk),
        .rst_n    (rst_n),
        .link     (u_link.slave),
        .notice   (notice_slave),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    // master digit follows the switches directly
    seg_display u_seg_master (
        .code (tx_code),
        .seg  (seg_master)
    );

    seg_display u_seg_slave (
        .code (rx_data),
        .seg  (seg_slave)
    );

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`default_nettype none

module clk_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on an edge like any other input
    end

endmodule

`default_nettype wire

// ==== dv/pb_link_chk.sv ====
`default_nettype none

module pb_link_chk import pb_link_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  request,
    input logic  ack,
    input logic  valid,
    input code_t data,
    input logic  rx_valid
);

    a_req_valid_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(request && valid))
        else $error("request and valid high in the same cycle");

    a_rx_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid)
        else $error("rx_valid high for more than one cycle");

    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (valid && $past(valid)) |-> $stable(data))
        else $error("link data moved while valid was high");

    // ack only comes down once the slave has taken data
    a_ack_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack) |-> $past(valid))
        else $error("ack dropped without valid");

endmodule

bind pb_link_top pb_link_chk i_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .request  (u_link.request),
    .ack      (u_link.ack),
    .valid    (u_link.valid),
    .data     (u_link.data),
    .rx_valid (rx_valid)
);

`default_nettype wire

// ==== dv/pb_link_tb.sv ====
`default_nettype none

module pb_link_tb import pb_link_pkg::*; ();

    localparam int HOLD           = 20;
    localparam int TIMEOUT_CYCLES = 400;
    localparam logic [6:0] SEG_TABLE [8] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78
    };

    logic       clk;
    logic       rst_n;
    logic [7:0] sw;
    logic       send_btn;
    logic       notice_master;
    logic       notice_slave;
    code_t      rx_data;
    logic       rx_valid;
    logic [6:0] seg_master;
    logic [6:0] seg_slave;

    integer     seed = 32'h2f315176;
    int         value_errors = 0;
    int         other_failures = 0;
    int         rx_count = 0;
    code_t      rx_data_seen;
    logic [6:0] seg_slave_seen;
    int         slave_run = 0;
    int         master_run = 0;
    int         slave_lit = 0; // total cycles with notice_slave high
    int         notice_who[$]; // 1 slave, 2 master
    int         notice_len[$];

    clk_gen #(.PERIOD(4), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst_n(rst_n));

    pb_link_top #(.HOLD_CYCLES(HOLD), .DEBOUNCE_LEN(4)) i_dut (.*);

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (rx_valid) begin
                rx_count++;
                rx_data_seen   = rx_data;
                seg_slave_seen = seg_slave;
            end
            if (notice_slave) begin
                slave_run++;
                slave_lit++;
            end else if (slave_run != 0) begin
                notice_who.push_back(1);
                notice_len.push_back(slave_run);
                slave_run = 0;
            end
            if (notice_master) begin
                master_run++;
            end else if (master_run != 0) begin
                notice_who.push_back(2);
                notice_len.push_back(master_run);
                master_run = 0;
            end
        end
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic code_t expected_code(input logic [7:0] s);
        code_t c;
        c = '0;
        if ($countones(s) == 1) begin
            for (int b = 0; b < 8; b++) begin
                if (s[b]) c = code_t'(b);
            end
        end
        return c;
    endfunction

    function automatic logic [7:0] pick_switches();
        logic [7:0] v;
        if (rand_below(5) == 0) begin
            v = 8'($random(seed));
            if ($countones(v) == 1) v = v | 8'h81; // force two or more bits
        end else begin
            v = 8'h01 << rand_below(8);
        end
        return v;
    endfunction

    task automatic compare_code(input string name, input code_t exp, input code_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_seg(input string name, input logic [6:0] exp, input logic [6:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %07b, actual %07b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic wait_rx(input string name, input int base);
        int cycles;
        cycles = 0;
        while (rx_count == base && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_count == base) begin
            $display("%s: rx_valid never arrived", name);
            other_failures++;
        end
    endtask

    task automatic do_transfer(input string name, input logic [7:0] sw_val, input bit again);
        int    base;
        int    lit;
        int    press_len;
        code_t exp_code;
        base      = rx_count;
        lit       = slave_lit;
        press_len = 6 + rand_below(5);
        exp_code  = expected_code(sw_val);
        notice_who.delete();
        notice_len.delete();
        @(posedge clk);
        sw       <= sw_val;
        send_btn <= 1'b1;
        @(negedge clk);
        compare_seg({name, " seg_master"}, SEG_TABLE[exp_code], seg_master);
        repeat (press_len) @(posedge clk);
        send_btn <= 1'b0;
        if (again) begin // lands while the master is still busy
            repeat (2) @(posedge clk);
            send_btn <= 1'b1;
            repeat (press_len) @(posedge clk);
            send_btn <= 1'b0;
        end
        wait_rx(name, base);
        repeat (HOLD) @(posedge clk); // link is idle again well before this
        compare_count({name, " rx_valid count"}, base + 1, rx_count);
        compare_code({name, " rx_data"}, exp_code, rx_data_seen);
        compare_seg({name, " seg_slave"}, SEG_TABLE[exp_code], seg_slave_seen);
        compare_count({name, " notice_slave cycles"}, lit + HOLD, slave_lit);
        compare_count({name, " notice runs"}, 2, notice_len.size());
        if (notice_len.size() == 2) begin
            compare_count({name, " slave notice first"}, 1, notice_who[0]);
            compare_count({name, " notice_slave length"}, HOLD, notice_len[0]);
            compare_count({name, " notice_master length"}, HOLD, notice_len[1]);
        end
    endtask

    task automatic do_glitch(input string name);
        int base;
        int lit;
        int len;
        base = rx_count;
        lit  = slave_lit;
        len  = 1 + rand_below(3);
        @(posedge clk);
        send_btn <= 1'b1;
        repeat (len) @(posedge clk);
        send_btn <= 1'b0;
        repeat (20) @(posedge clk);
        compare_count({name, " rx_valid count"}, base, rx_count);
        compare_count({name, " notice_slave cycles"}, lit, slave_lit); // no request went out
    endtask

    initial begin
        int cycles;
        sw       = '0;
        send_btn = 1'b0;
        cycles   = 0;
        @(posedge clk);
        while (rst_n !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            other_failures++;
        end
        @(negedge clk);
        compare_count("reset notice_master", 0, notice_master);
        compare_count("reset notice_slave", 0, notice_slave);
        compare_count("reset rx_valid", 0, rx_valid);
        compare_code("reset rx_data", 3'd0, rx_data);
        compare_seg("reset seg_slave", SEG_TABLE[0], seg_slave);
        for (int i = 0; i < 10; i++) begin
            do_transfer($sformatf("transfer %0d", i), pick_switches(), 1'b0);
        end
        do_transfer("two switches", 8'b0011_0000, 1'b0);
        for (int i = 0; i < 3; i++) begin
            do_glitch($sformatf("glitch %0d", i));
        end
        for (int i = 0; i < 2; i++) begin
            do_transfer($sformatf("double press %0d", i), pick_switches(), 1'b1);
        end
        $display("value errors: %0d, other failures: %0d", value_errors, other_failures);
        if (value_errors + other_failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pb_link.f ====
hdl/pb_link_pkg.sv
hdl/link_if.sv
hdl/btn_conditioner.sv
hdl/hold_timer.sv
hdl/master_ctrl.sv
hdl/slave_ctrl.sv
hdl/seg_display.sv
hdl/pb_link_top.sv
dv/clk_gen.sv
dv/pb_link_chk.sv
dv/pb_link_tb.sv

// ==== Bender.yml ====
package:
  name: pb_link

sources:
  - hdl/pb_link_pkg.sv
  - hdl/link_if.sv
  - hdl/btn_conditioner.sv
  - hdl/hold_timer.sv
  - hdl/master_ctrl.sv
  - hdl/slave_ctrl.sv
  - hdl/seg_display.sv
  - hdl/pb_link_top.sv
  - target: simulation
    files:
      - dv/clk_gen.sv
      - dv/pb_link_chk.sv
      - dv/pb_link_tb.sv
